/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_exec_tb -f sim.f -o rv_exec_sim
./obj_dir/rv_exec_sim > sim.log 2>&1
cat sim.log

if grep -qx "All checks passed" sim.log; then
  exit 0
else
  exit 1
fi

/* sim.f */
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_alu.sv
source/rv_branch_unit.sv
source/rv_commit.sv
source/rv_exec_top.sv
verif/rv_exec_tb.sv

/* source/rv_alu.sv */
`timescale 1ns/10ps

module rv_alu (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::dec_t     dec,
  output rv_pkg::alu_res_t alu_res
);
  import rv_pkg::*;

  logic [31:0] result;
  logic [4:0]  shamt;

  assign shamt = dec.op_b[4:0];

  always_comb
  begin
    case (dec.alu_op)
      ALU_ADD:  result = dec.op_a + dec.op_b;
      ALU_SUB:  result = dec.op_a - dec.op_b;
      ALU_SLL:  result = dec.op_a << shamt;
      ALU_SLT:  result = {31'd0, $signed(dec.op_a) < $signed(dec.op_b)};
      ALU_SLTU: result = {31'd0, dec.op_a < dec.op_b};
      ALU_XOR:  result = dec.op_a ^ dec.op_b;
      ALU_SRL:  result = dec.op_a >> shamt;
      ALU_SRA:  result = $unsigned($signed(dec.op_a) >>> shamt);
      ALU_OR:   result = dec.op_a | dec.op_b;
      ALU_AND:  result = dec.op_a & dec.op_b;
      default:  result = dec.op_b;  // Pass B for LUI and links
    endcase
  end

  always_ff @(posedge clk)
  begin
    alu_res.valid   <= dec.valid;
    alu_res.we      <= dec.valid & dec.writes_rd & ~dec.illegal;
    alu_res.illegal <= dec.valid & dec.illegal;
    alu_res.rd      <= dec.rd;
    alu_res.data    <= result;
    if (rst)
    begin
      alu_res.valid   <= 1'b0;
      alu_res.we      <= 1'b0;
      alu_res.illegal <= 1'b0;
    end
  end

  // Result follows one cycle behind a single-cycle operation
  a_alu_lat: assert property (@(posedge clk) disable iff (rst)
    dec.valid |=> alu_res.valid && !dec.valid);

endmodule

/* source/rv_branch_unit.sv */
`timescale 1ns/10ps

module rv_branch_unit (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::dec_t    dec,
  output rv_pkg::br_res_t br_res
);
  import rv_pkg::*;

  logic        eq;
  logic        lt;
  logic        ltu;
  logic        taken;
  logic [31:0] seq_pc;
  logic [31:0] next_pc;

  assign eq     = dec.rs1_val == dec.rs2_val;
  assign lt     = $signed(dec.rs1_val) < $signed(dec.rs2_val);
  assign ltu    = dec.rs1_val < dec.rs2_val;
  assign seq_pc = dec.pc + 32'd4;  // Also the link value

  always_comb
  begin
    case (dec.br_op)
      BR_JAL:  taken = 1'b1;
      BR_JALR: taken = 1'b1;
      BR_BEQ:  taken = eq;
      BR_BNE:  taken = !eq;
      BR_BLT:  taken = lt;
      BR_BGE:  taken = !lt;
      BR_BLTU: taken = ltu;
      BR_BGEU: taken = !ltu;
      default: taken = 1'b0;
    endcase
    if (dec.br_op == BR_JALR)
      next_pc = (dec.rs1_val + dec.imm) & ~32'd1;
    else if (taken)
      next_pc = dec.pc + dec.imm;
    else
      next_pc = seq_pc;
  end

  always_ff @(posedge clk)
  begin
    br_res.valid   <= dec.valid;
    br_res.taken   <= dec.valid & taken;
    br_res.link_we <= dec.valid & (dec.br_op == BR_JAL || dec.br_op == BR_JALR);
    br_res.next_pc <= next_pc;
    br_res.link    <= seq_pc;
    if (rst)
    begin
      br_res.valid   <= 1'b0;
      br_res.taken   <= 1'b0;
      br_res.link_we <= 1'b0;
    end
  end

  // Targets stay word aligned
  a_pc_align: assert property (@(posedge clk) disable iff (rst)
    br_res.valid |-> br_res.next_pc[1:0] == 2'b00);

endmodule

/* source/rv_commit.sv */
`timescale 1ns/10ps

module rv_commit #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::alu_res_t alu_res,
  input  rv_pkg::br_res_t  br_res,
  input  logic [4:0]       rs1_addr,
  input  logic [4:0]       rs2_addr,
  output logic [31:0]      rs1_data,
  output logic [31:0]      rs2_data,
  output logic [31:0]      pc,
  output logic             retire,
  output logic             illegal,
  output logic             rd_we,
  output logic [4:0]       rd_addr,
  output logic [31:0]      rd_data
);

  logic [31:0] regs [1:31];  // x0 is not stored
  logic [31:0] wdata;
  logic        wen;

  assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

  // Link value wins for JAL and JALR
  assign wdata = br_res.link_we ? br_res.link : alu_res.data;
  assign wen   = alu_res.valid & alu_res.we & (alu_res.rd != 5'd0);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc      <= RESET_PC;
      retire  <= 1'b0;
      illegal <= 1'b0;
      rd_we   <= 1'b0;
      for (int i = 1; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else
    begin
      retire  <= alu_res.valid;
      illegal <= alu_res.valid & alu_res.illegal;
      rd_we   <= wen;
      if (br_res.valid)
        pc <= br_res.next_pc;
      if (wen)
        regs[alu_res.rd] <= wdata;
    end
  end

  always_ff @(posedge clk)
  begin
    rd_addr <= alu_res.rd;
    rd_data <= wdata;
  end

  // Both execute units advance in lockstep
  a_exec_sync: assert property (@(posedge clk) disable iff (rst) alu_res.valid == br_res.valid);

endmodule

/* source/rv_decoder.sv */
`timescale 1ns/10ps

module rv_decoder #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           instr_valid,
  input  rv_pkg::instr_u instr,
  input  logic [31:0]    pc,
  input  logic [31:0]    rs1_data,
  input  logic [31:0]    rs2_data,
  output logic [4:0]     rs1_addr,
  output logic [4:0]     rs2_addr,
  output rv_pkg::dec_t   dec
);
  import rv_pkg::*;

  logic        instr_vld_q;
  instr_u      instr_q;
  dec_t        dec_d;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [31:0] imm_i;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  function automatic alu_op_e alu_sel(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_ff @(posedge clk)
  begin
    if (instr_valid)
    begin
      instr_q <= instr;
    end
    instr_vld_q <= instr_valid;
    if (rst)
    begin
      instr_vld_q <= 1'b0;
    end
  end

  assign rs1_addr = instr_q.r.rs1;  // Register file read happens in this cycle
  assign rs2_addr = instr_q.r.rs2;
  assign f3       = instr_q.r.funct3;
  assign f7       = instr_q.r.funct7;

  assign imm_i = {{20{instr_q.i.imm_11_0[11]}}, instr_q.i.imm_11_0};
  assign imm_b = {{19{instr_q.b.imm_12}}, instr_q.b.imm_12, instr_q.b.imm_11,
                  instr_q.b.imm_10_5, instr_q.b.imm_4_1, 1'b0};
  assign imm_u = {instr_q.u.imm_31_12, 12'd0};
  assign imm_j = {{11{instr_q.j.imm_20}}, instr_q.j.imm_20, instr_q.j.imm_19_12,
                  instr_q.j.imm_11, instr_q.j.imm_10_1, 1'b0};

  always_comb
  begin
    dec_d         = '0;
    dec_d.valid   = instr_vld_q;
    dec_d.alu_op  = ALU_ADD;
    dec_d.br_op   = BR_SEQ;
    dec_d.rd      = instr_q.r.rd;
    dec_d.op_a    = rs1_data;
    dec_d.op_b    = rs2_data;
    dec_d.rs1_val = rs1_data;
    dec_d.rs2_val = rs2_data;
    dec_d.imm     = imm_i;
    dec_d.pc      = pc;
    case (instr_q.r.opcode)
      OP:
      begin
        dec_d.writes_rd = 1'b1;
        dec_d.alu_op    = alu_sel(f3, f7[5]);
        dec_d.illegal   = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
      end
      OP_IMM:
      begin
        dec_d.writes_rd = 1'b1;
        dec_d.op_b      = imm_i;
        dec_d.alu_op    = alu_sel(f3, f3 == 3'b101 && f7[5]);  // ADDI has no SUB form
        if (f3 == 3'b001)
          dec_d.illegal = f7 != 7'h00;
        else if (f3 == 3'b101)
          dec_d.illegal = f7 != 7'h00 && f7 != 7'h20;
      end
      LUI:
      begin
        dec_d.writes_rd = 1'b1;
        dec_d.alu_op    = ALU_PASS_B;
        dec_d.op_a      = '0;
        dec_d.op_b      = imm_u;
        dec_d.imm       = imm_u;
      end
      AUIPC:
      begin
        dec_d.writes_rd = 1'b1;
        dec_d.op_a      = pc;
        dec_d.op_b      = imm_u;
        dec_d.imm       = imm_u;
      end
      JAL:
      begin
        dec_d.writes_rd = 1'b1;  // Link data comes from the branch unit
        dec_d.alu_op    = ALU_PASS_B;
        dec_d.br_op     = BR_JAL;
        dec_d.op_b      = imm_j;
        dec_d.imm       = imm_j;
      end
      JALR:
      begin
        dec_d.writes_rd = 1'b1;
        dec_d.alu_op    = ALU_PASS_B;
        dec_d.br_op     = BR_JALR;
        dec_d.op_b      = imm_i;
        dec_d.illegal   = f3 != 3'b000;
      end
      BRANCH:
      begin
        dec_d.imm = imm_b;
        case (f3)
          3'b000:  dec_d.br_op = BR_BEQ;
          3'b001:  dec_d.br_op = BR_BNE;
          3'b100:  dec_d.br_op = BR_BLT;
          3'b101:  dec_d.br_op = BR_BGE;
          3'b110:  dec_d.br_op = BR_BLTU;
          3'b111:  dec_d.br_op = BR_BGEU;
          default: dec_d.illegal = 1'b1;
        endcase
      end
      MISC_MEM: dec_d.illegal = f3 != 3'b000;  // Plain FENCE only
      SYSTEM:   dec_d.illegal = f3 != 3'b000 || instr_q.i.imm_11_0[11:1] != '0;
      default:  dec_d.illegal = 1'b1;
    endcase
    if (dec_d.illegal)
    begin
      dec_d.writes_rd = 1'b0;
      dec_d.br_op     = BR_SEQ;
    end
  end

  always_ff @(posedge clk)
  begin
    dec <= dec_d;
    if (rst)
    begin
      dec.valid <= 1'b0;
      dec.pc    <= RESET_PC;
    end
  end

  // Issuer keeps one instruction in flight
  a_single_issue: assert property (@(posedge clk) disable iff (rst) dec.valid |-> !instr_valid);

endmodule

/* source/rv_exec_top.sv */
`timescale 1ns/10ps

module rv_exec_top #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           instr_valid,
  input  rv_pkg::instr_u instr,
  output logic           retire,
  output logic           illegal,
  output logic           rd_we,
  output logic [4:0]     rd_addr,
  output logic [31:0]    rd_data,
  output logic [31:0]    pc
);
  import rv_pkg::*;

  dec_t        dec;
  alu_res_t    alu_res;
  br_res_t     br_res;
  logic [4:0]  rs1_addr;
  logic [4:0]  rs2_addr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;

  rv_decoder #(.RESET_PC(RESET_PC)) rv_decoder_inst (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .dec         (dec)
  );

  rv_alu rv_alu_inst (
    .clk     (clk),
    .rst     (rst),
    .dec     (dec),
    .alu_res (alu_res)
  );

  rv_branch_unit rv_branch_unit_inst (
    .clk    (clk),
    .rst    (rst),
    .dec    (dec),
    .br_res (br_res)
  );

  rv_commit #(.RESET_PC(RESET_PC)) rv_commit_inst (
    .clk      (clk),
    .rst      (rst),
    .alu_res  (alu_res),
    .br_res   (br_res),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc),
    .retire   (retire),
    .illegal  (illegal),
    .rd_we    (rd_we),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

/* source/rv_pkg.sv */
package rv_pkg;

  // RV32I major opcodes
  localparam logic [6:0] OP       = 7'b0110011;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] LUI      = 7'b0110111;
  localparam logic [6:0] AUIPC    = 7'b0010111;
  localparam logic [6:0] JAL      = 7'b1101111;
  localparam logic [6:0] JALR     = 7'b1100111;
  localparam logic [6:0] BRANCH   = 7'b1100011;
  localparam logic [6:0] MISC_MEM = 7'b0001111;
  localparam logic [6:0] SYSTEM   = 7'b1110011;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_SEQ, BR_JAL, BR_JALR, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
  } br_op_e;

  typedef struct packed {
    logic        valid;
    alu_op_e     alu_op;
    br_op_e      br_op;
    logic        writes_rd;
    logic [4:0]  rd;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm;
    logic [31:0] pc;
    logic        illegal;
  } dec_t;

  typedef struct packed {
    logic        valid;
    logic        we;
    logic        illegal;
    logic [4:0]  rd;
    logic [31:0] data;
  } alu_res_t;

  typedef struct packed {
    logic        valid;
    logic        taken;
    logic        link_we;
    logic [31:0] next_pc;
    logic [31:0] link;
  } br_res_t;

endpackage

/* verif/rv_exec_tb.sv */
`timescale 1ns/10ps

module rv_exec_tb;
  import rv_pkg::*;

  localparam logic [31:0] RESET_PC         = 32'h0000_1000;
  localparam int          CLK_PERIOD       = 40;
  localparam int          NUM_INSTRS       = 66;
  localparam int          CYCLES_PER_INSTR = 5;  // Issue gap, strobe and three stages
  localparam int          TIMEOUT_NS       = (NUM_INSTRS * CYCLES_PER_INSTR + 20) * CLK_PERIOD;

  logic        clk;
  logic        rst;
  logic        instr_valid;
  instr_u      instr;
  logic        retire;
  logic        illegal;
  logic        rd_we;
  logic [4:0]  rd_addr;
  logic [31:0] rd_data;
  logic [31:0] pc;

  // Architectural reference state
  logic [31:0] m_regs [32];
  logic [31:0] m_pc;
  int          checks;
  int          errors;

  rv_exec_top #(.RESET_PC(RESET_PC)) rv_exec_top_inst (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .retire      (retire),
    .illegal     (illegal),
    .rd_we       (rd_we),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .pc          (pc)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
  endfunction

  function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << sh;
      3'd2:    return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? (a[31] ? ~(~a >> sh) : a >> sh) : a >> sh;
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Retires one instruction in the reference state
  task automatic model_step(input logic [31:0] w, output logic ill, output logic we,
                            output logic [31:0] data);
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] nxt;
    logic        tk;
    rd    = w[11:7];
    a     = m_regs[w[19:15]];
    b     = m_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    ill   = 1'b0;
    we    = 1'b0;
    data  = '0;
    tk    = 1'b0;
    nxt   = m_pc + 32'd4;
    case (w[6:0])
      OP:
      begin
        we   = 1'b1;
        data = alu_ref(w[14:12], w[30], a, b);
      end
      OP_IMM:
      begin
        we   = 1'b1;
        data = alu_ref(w[14:12], w[30] && w[14:12] == 3'b101, a, imm_i);
      end
      LUI:
      begin
        we   = 1'b1;
        data = {w[31:12], 12'd0};
      end
      AUIPC:
      begin
        we   = 1'b1;
        data = m_pc + {w[31:12], 12'd0};
      end
      JAL:
      begin
        we   = 1'b1;
        data = m_pc + 32'd4;
        nxt  = m_pc + imm_j;
      end
      JALR:
      begin
        we   = 1'b1;
        data = m_pc + 32'd4;
        nxt  = (a + imm_i) & 32'hffff_fffe;
      end
      BRANCH:
      begin
        case (w[14:12])
          3'b000:  tk = a == b;
          3'b001:  tk = a != b;
          3'b100:  tk = $signed(a) < $signed(b);
          3'b101:  tk = $signed(a) >= $signed(b);
          3'b110:  tk = a < b;
          default: tk = a >= b;
        endcase
        if (tk)
          nxt = m_pc + imm_b;
      end
      MISC_MEM, SYSTEM:
        we = 1'b0;  // Only the PC moves
      default:
        ill = 1'b1;
    endcase
    if (rd == 5'd0)
      we = 1'b0;
    if (we)
      m_regs[rd] = data;
    m_pc = nxt;
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error: %s is 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input logic [4:0] got, input logic [4:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error: %s is 0x%02h, expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int start);
    $display("test %-14s finished with %0d mismatches", name, errors - start);
  endtask

  // Issues one instruction and checks the retire cycle
  task automatic run_instr(input logic [31:0] w);
    logic        exp_ill;
    logic        exp_we;
    logic [31:0] exp_data;
    model_step(w, exp_ill, exp_we, exp_data);
    @(negedge clk);
    check_bit("retire", retire, 1'b0);  // Previous pulse lasted one cycle
    instr       = w;
    instr_valid = 1'b1;
    @(negedge clk);
    instr_valid = 1'b0;
    repeat (3) @(negedge clk);
    check_bit("retire", retire, 1'b1);
    check_bit("illegal", illegal, exp_ill);
    check_bit("rd_we", rd_we, exp_we);
    if (exp_we)
    begin
      check_reg("rd_addr", rd_addr, w[11:7]);
      check_word("rd_data", rd_data, exp_data);
    end
    check_word("pc", pc, m_pc);
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
    logic [19:0] upper;
    upper = 20'((v + 32'h800) >> 12);  // Rounds for the sign of the low part
    run_instr({upper, rd, LUI});
    run_instr(i_word(v[11:0], rd, 3'b000, rd, OP_IMM));
  endtask

  task automatic test_reset();
    int start;
    start = errors;
    check_word("pc", pc, RESET_PC);
    repeat (3)
    begin
      @(negedge clk);
      check_bit("retire", retire, 1'b0);
      check_bit("rd_we", rd_we, 1'b0);
      check_word("pc", pc, RESET_PC);
    end
    report_test("reset", start);
  endtask

  task automatic test_alu();
    int          start;
    logic [11:0] imm;
    start = errors;
    load_reg(5'd1, $urandom | 32'h8000_0000);  // Negative operand separates SLT and SRA
    load_reg(5'd2, ($urandom & 32'h7fff_ffff) | 32'h1);  // Positive with a nonzero shift
    for (int f = 0; f < 8; f++)
      run_instr(r_word(7'h00, 5'd2, 5'd1, f[2:0], 5'd10 + f[4:0]));
    run_instr(r_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd18));  // SUB
    run_instr(r_word(7'h20, 5'd2, 5'd1, 3'b101, 5'd19));  // SRA
    for (int f = 0; f < 8; f++)
    begin
      imm = 12'($urandom);
      if (f == 1 || f == 5)
        imm[11:5] = 7'h00;
      run_instr(i_word(imm, 5'd1, f[2:0], 5'd20 + f[4:0], OP_IMM));
    end
    run_instr(i_word({7'h20, 5'($urandom) | 5'd1}, 5'd1, 3'b101, 5'd28, OP_IMM));  // SRAI
    report_test("alu", start);
  endtask

  task automatic test_branches();
    int          start;
    logic [12:0] off;
    start = errors;
    load_reg(5'd5, $urandom);
    for (int c = 0; c < 4; c++)
    begin
      case (c)
        0:       run_instr(i_word(12'h000, 5'd5, 3'b000, 5'd6, OP_IMM));
        1:       run_instr(i_word(12'($urandom_range(1, 200)), 5'd5, 3'b000, 5'd6, OP_IMM));
        2:       run_instr(i_word(-12'($urandom_range(1, 200)), 5'd5, 3'b000, 5'd6, OP_IMM));
        default: run_instr(i_word(12'h800, 5'd5, 3'b100, 5'd6, OP_IMM));  // Opposite signs
      endcase
      for (int f = 0; f < 8; f++)
      begin
        if (f == 2 || f == 3)
          continue;
        off = 13'($urandom) & 13'h1ffc;
        run_instr(b_word(off, 5'd6, 5'd5, f[2:0]));
      end
    end
    report_test("branches", start);
  endtask

  task automatic test_jumps();
    int start;
    start = errors;
    run_instr(j_word(21'($urandom) & 21'h1ffffc, 5'd7));
    // Odd offset, so the target needs bit 0 cleared
    run_instr(i_word((12'($urandom) & 12'hffc) | 12'h001, 5'd7, 3'b000, 5'd8, JALR));
    run_instr(i_word(12'h010, 5'd8, 3'b000, 5'd8, JALR));
    run_instr(j_word(21'($urandom) & 21'h1ffffc, 5'd0));
    report_test("jumps", start);
  endtask

  task automatic test_auipc_x0();
    int start;
    start = errors;
    run_instr({20'($urandom), 5'd9, AUIPC});
    run_instr(i_word(12'($urandom), 5'd1, 3'b000, 5'd0, OP_IMM));
    run_instr(r_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd9));
    run_instr(r_word(7'h00, 5'd1, 5'd0, 3'b000, 5'd10));
    report_test("auipc and x0", start);
  endtask

  task automatic test_misc();
    int start;
    start = errors;
    run_instr({25'($urandom), 7'h7f});
    run_instr({25'($urandom), 7'b0000011});  // Loads are not supported
    run_instr(32'h0ff0_000f);  // FENCE
    run_instr(32'h0000_0073);  // ECALL
    run_instr(32'h0010_0073);  // EBREAK
    report_test("misc", start);
  endtask

  initial
  begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before the tests finished");
    $display("Checks failed");
    $finish;
  end

  initial
  begin
    void'($urandom(99));
    clk         = 1'b0;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    checks      = 0;
    errors      = 0;
    m_pc        = RESET_PC;
    for (int i = 0; i < 32; i++)
      m_regs[i] = '0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_alu();
    test_branches();
    test_jumps();
    test_auipc_x0();
    test_misc();
    $display("Ran %0d checks with %0d errors", checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule
